/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
	-f src.f \
	--top-module m68kDramControllerTb \
	-o simv
./obj_dir/simv | tee sim.log

if grep -q "all tests passed" sim.log; then
	echo "simulation PASSED"
else
	echo "simulation FAILED"
	exit 1
fi

/* src.f */
src/sdramPkg.sv
src/cpuBusPort.sv
src/sdramSequencer.sv
src/sdramPhy.sv
src/m68kDramController.sv
tests/sdramModel.sv
tests/m68kDramControllerTb.sv

/* src/cpuBusPort.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuBusPort (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire sdramPkg::cpuAddrT Address,
	input wire sdramPkg::dataWordT DataIn,
	input wire logic UDS_L,
	input wire logic LDS_L,
	input wire logic DramSelect_L,
	input wire logic WE_L,
	input wire logic AS_L,
	output sdramPkg::memReqT memReq,
	output logic memReqValid,
	input wire logic memAck,
	input wire sdramPkg::dataWordT readData,
	output logic Dtack_L,
	output sdramPkg::dataWordT DataOut
);
	import sdramPkg::*;

	typedef enum logic [1:0] {
		PortIdle,	// no bus cycle for us
		PortWait,	// request out, waiting for the sequencer
		PortHold,	// Dtack low until the strobes go away
		PortRelease	// waiting for memAck to fall
	} portStateT;

	portStateT state;
	logic cycleStart;

	// a write waits for a strobe so DataIn is valid
	assign cycleStart = !DramSelect_L && !AS_L && (WE_L || !UDS_L || !LDS_L);

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= PortIdle;
			memReqValid <= 1'b0;
			Dtack_L <= 1'b1;
		end else begin
			case (state)
				PortIdle: if (cycleStart) begin
					memReqValid <= 1'b1;	// phase 1
					state <= PortWait;
				end
				PortWait: if (memAck) begin
					Dtack_L <= 1'b0;	// access done, end the bus cycle
					state <= PortHold;
				end
				PortHold: if (UDS_L && LDS_L) begin
					Dtack_L <= 1'b1;
					memReqValid <= 1'b0;	// phase 3
					state <= PortRelease;
				end
				PortRelease: if (!memAck)
					state <= PortIdle;	// phase 4 seen
				default: state <= PortIdle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == PortIdle && cycleStart) begin
			memReq.write <= !WE_L;
			memReq.bank <= Address[BankHi:BankLo];
			memReq.row <= Address[RowHi:RowLo];
			memReq.col <= Address[ColHi:ColLo];
			memReq.data <= DataIn;
		end
		if (state == PortWait && memAck && !memReq.write)
			DataOut <= readData;	// held for the rest of the bus cycle
	end

	memReqStable: assert property (@(posedge Clock) disable iff (!Reset_L)
		memReqValid |=> !memReqValid || $stable(memReq))
		else $error("memReq changed while memReqValid high");

endmodule

`default_nettype wire

/* src/m68kDramController.sv */
`timescale 1ns/1ns
`default_nettype none

module m68kDramController (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire sdramPkg::cpuAddrT Address,	// 68000 side
	input wire sdramPkg::dataWordT DataIn,
	input wire logic UDS_L,
	input wire logic LDS_L,
	input wire logic DramSelect_L,
	input wire logic WE_L,
	input wire logic AS_L,
	output sdramPkg::dataWordT DataOut,
	output logic Dtack_L,
	output logic ResetOut_L,	// held low until init is done
	output logic SDram_CKE_H,	// SDRAM side
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output sdramPkg::rowAddrT SDram_Addr,
	output sdramPkg::bankAddrT SDram_BA,
	inout wire sdramPkg::dataWordT SDram_DQ
);
	import sdramPkg::*;

	memReqT memReq;	// bus port to sequencer
	logic memReqValid;
	logic memAck;
	dataWordT readData;
	sdramBusT cmdBus;	// sequencer to PHY
	logic driveDq;
	dataWordT writeData;
	logic latchRead;
	dataWordT dqCapture;

	cpuBusPort cpuBusPort_inst (.*);
	sdramSequencer sdramSequencer_inst (.*);
	sdramPhy sdramPhy_inst (.*);

endmodule

`default_nettype wire

/* src/sdramPhy.sv */
`timescale 1ns/1ns
`default_nettype none

module sdramPhy (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire sdramPkg::sdramBusT cmdBus,
	input wire logic driveDq,
	input wire sdramPkg::dataWordT writeData,
	input wire logic latchRead,
	output sdramPkg::dataWordT dqCapture,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output sdramPkg::rowAddrT SDram_Addr,
	output sdramPkg::bankAddrT SDram_BA,
	inout wire sdramPkg::dataWordT SDram_DQ
);
	import sdramPkg::*;

	dataWordT dqOut;	// registered write data
	logic dqOutEn;	// registered DQ enable

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= PoweringUp;
			dqOutEn <= 1'b0;	// bus released
		end else begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= cmdBus.cmd;
			dqOutEn <= driveDq;
		end
	end

	always_ff @(posedge Clock) begin
		SDram_Addr <= cmdBus.addr;	// lines up with the command pins
		SDram_BA <= cmdBus.bank;
		dqOut <= writeData;
	end

	assign SDram_DQ = dqOutEn ? dqOut : 'z;

	// mid-cycle sample, away from the rising edge where DQ changes
	always_ff @(negedge Clock) begin
		if (latchRead)
			dqCapture <= SDram_DQ;
	end

endmodule

`default_nettype wire

/* src/sdramPkg.sv */
`default_nettype none

package sdramPkg;

	//////////////////////////////
	// widths
	typedef logic [31:0] cpuAddrT;	// 68000 address bus
	typedef logic [15:0] dataWordT;	// one SDRAM / CPU data word
	typedef logic [12:0] rowAddrT;	// row address, also the A12..A0 pins
	typedef logic [9:0] colAddrT;	// column address
	typedef logic [1:0] bankAddrT;	// BA1..BA0

	// pin pattern CKE, CS_L, RAS_L, CAS_L, WE_L
	typedef enum logic [4:0] {
		PoweringUp = 5'b00000,	// CKE and CS low during the power-up wait
		Nop = 5'b10111,
		AutoRefresh = 5'b10001,
		BankActivate = 5'b10011,	// row on A12..A0
		PrechargeAll = 5'b10010,	// needs A10 high
		ModeRegisterSet = 5'b10000,
		ReadCmd = 5'b10101,	// A10 high gives auto precharge
		WriteCmd = 5'b10100
	} sdramCmdT;

	typedef struct packed {
		logic write;	// 1 for a CPU write
		bankAddrT bank;
		rowAddrT row;
		colAddrT col;
		dataWordT data;	// write data, whole word
	} memReqT;

	typedef struct packed {
		sdramCmdT cmd;
		rowAddrT addr;
		bankAddrT bank;
	} sdramBusT;

	//////////////////////////////
	// timing, in clocks
	localparam logic [15:0] PowerUpCycles = 16'd8;	// short for simulation
	localparam logic [15:0] InitRefreshWindow = 16'd40;
	localparam logic [15:0] InitRefreshSpacing = 16'd3;
	localparam logic [15:0] RefreshInterval = 16'd375;	// 7.5 us at 50 MHz
	localparam logic [15:0] CasLatency = 16'd2;
	localparam logic [12:0] ModeRegisterValue = 13'h220;	// burst 1, CL 2, single write

	// CPU address map
	localparam int BankHi = 25;
	localparam int BankLo = 24;
	localparam int RowHi = 23;
	localparam int RowLo = 11;
	localparam int ColHi = 10;
	localparam int ColLo = 1;	// A0 unused on a word bus
	localparam int AutoPrechargeBit = 10;

endpackage

`default_nettype wire

/* src/sdramSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module sdramSequencer (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire sdramPkg::memReqT memReq,
	input wire logic memReqValid,
	output logic memAck,
	output sdramPkg::dataWordT readData,
	output sdramPkg::sdramBusT cmdBus,
	output logic driveDq,
	output sdramPkg::dataWordT writeData,
	output logic latchRead,
	input wire sdramPkg::dataWordT dqCapture,
	output logic ResetOut_L
);
	import sdramPkg::*;

	typedef enum logic [3:0] {
		SeqPowerUp,
		SeqPrecharge,
		SeqRefreshWindow,	// init refreshes
		SeqModeSet,
		SeqIdle,
		SeqIdlePrecharge,
		SeqIdleRefresh,
		SeqRefreshNop,	// three NOPs for tRFC
		SeqActivate,
		SeqRead,
		SeqCasWait,
		SeqWrite,
		SeqRelease	// memAck high until memReqValid falls
	} seqStateT;

	seqStateT state;
	seqStateT nextState;
	logic [15:0] timer;
	logic [15:0] timerValue;
	logic timerLoad;
	logic timerDone;
	logic [15:0] refTimer;
	logic [15:0] refTimerValue;
	logic refTimerLoad;
	logic refTimerDone;

	assign readData = dqCapture;	// word latched on the falling edge
	assign writeData = memReq.data;
	assign timerDone = (timer == '0);
	assign refTimerDone = (refTimer == '0);

	//////////////////////////////
	// general and refresh timers count down and stop at 0
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			timer <= PowerUpCycles;	// power-up wait starts straight out of reset
			refTimer <= '0;
		end else begin
			if (timerLoad)
				timer <= timerValue;
			else if (!timerDone)
				timer <= timer - 16'd1;
			if (refTimerLoad)
				refTimer <= refTimerValue;
			else if (!refTimerDone)
				refTimer <= refTimer - 16'd1;
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= SeqPowerUp;
			memAck <= 1'b0;
			ResetOut_L <= 1'b0;
		end else begin
			state <= nextState;
			memAck <= (nextState == SeqRelease);
			if (state == SeqIdle && timerDone)
				ResetOut_L <= 1'b1;	// tMRD over so the CPU may run
		end
	end

	//////////////////////////////
	// next state and command
	always_comb begin
		nextState = state;
		cmdBus.cmd = Nop;
		cmdBus.addr = '0;
		cmdBus.bank = '0;
		driveDq = 1'b0;
		latchRead = 1'b0;
		timerLoad = 1'b0;
		timerValue = '0;
		refTimerLoad = 1'b0;
		refTimerValue = '0;

		case (state)
			SeqPowerUp: begin
				cmdBus.cmd = PoweringUp;	// CKE held low
				if (timerDone)
					nextState = SeqPrecharge;
			end
			SeqPrecharge: begin
				cmdBus.cmd = PrechargeAll;
				cmdBus.addr[AutoPrechargeBit] = 1'b1;
				timerLoad = 1'b1;
				timerValue = InitRefreshWindow;
				refTimerLoad = 1'b1;
				refTimerValue = InitRefreshSpacing;	// tRP before the first refresh
				nextState = SeqRefreshWindow;
			end
			SeqRefreshWindow: begin
				if (timerDone)
					nextState = SeqModeSet;
				else if (refTimerDone && timer > InitRefreshSpacing) begin
					cmdBus.cmd = AutoRefresh;	// none near the end keeps tRFC
					refTimerLoad = 1'b1;
					refTimerValue = InitRefreshSpacing;
				end
			end
			SeqModeSet: begin
				cmdBus.cmd = ModeRegisterSet;
				cmdBus.addr = ModeRegisterValue;
				timerLoad = 1'b1;
				timerValue = 16'd2;	// tMRD
				refTimerLoad = 1'b1;
				refTimerValue = RefreshInterval;
				nextState = SeqIdle;
			end
			SeqIdle: begin
				if (refTimerDone)
					nextState = SeqIdlePrecharge;	// refresh wins over a waiting access
				else if (memReqValid && timerDone)
					nextState = SeqActivate;
			end
			SeqIdlePrecharge: begin
				cmdBus.cmd = PrechargeAll;
				cmdBus.addr[AutoPrechargeBit] = 1'b1;
				nextState = SeqIdleRefresh;
			end
			SeqIdleRefresh: begin
				cmdBus.cmd = AutoRefresh;
				timerLoad = 1'b1;
				timerValue = InitRefreshSpacing - 16'd1;	// 3 NOPs as in the init window
				refTimerLoad = 1'b1;
				refTimerValue = RefreshInterval;
				nextState = SeqRefreshNop;
			end
			SeqRefreshNop: if (timerDone)
				nextState = SeqIdle;
			SeqActivate: begin
				cmdBus.cmd = BankActivate;
				cmdBus.addr = memReq.row;
				cmdBus.bank = memReq.bank;
				if (memReq.write) begin
					timerLoad = 1'b1;
					timerValue = 16'd1;	// one NOP before the write
					nextState = SeqWrite;
				end else begin
					nextState = SeqRead;
				end
			end
			SeqRead: begin
				cmdBus.cmd = ReadCmd;
				cmdBus.addr = {3'b000, memReq.col};
				cmdBus.addr[AutoPrechargeBit] = 1'b1;	// auto precharge
				cmdBus.bank = memReq.bank;
				timerLoad = 1'b1;
				timerValue = CasLatency;
				nextState = SeqCasWait;
			end
			SeqCasWait: if (timerDone) begin
				latchRead = 1'b1;	// data valid at this falling edge
				nextState = SeqRelease;
			end
			SeqWrite: if (timerDone) begin
				cmdBus.cmd = WriteCmd;
				cmdBus.addr = {3'b000, memReq.col};
				cmdBus.addr[AutoPrechargeBit] = 1'b1;
				cmdBus.bank = memReq.bank;
				driveDq = 1'b1;	// data goes out with the command
				nextState = SeqRelease;
			end
			SeqRelease: if (!memReqValid)
				nextState = SeqIdle;
			default: nextState = SeqPowerUp;
		endcase
	end

	ackOnlyWhileValid: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(memAck) |-> memReqValid)
		else $error("memAck rose without a request");

	// DQ only goes out while a write request is pending
	noDriveOnRead: assert property (@(posedge Clock) disable iff (!Reset_L)
		driveDq |-> memReqValid && memReq.write)
		else $error("DQ driven during a read");

endmodule

`default_nettype wire

/* tests/m68kDramControllerTb.sv */
`timescale 1ns/1ns
`default_nettype none

module m68kDramControllerTb;
	import sdramPkg::*;

	localparam int NumRows = 20;
	localparam int Passes = 3;	// repeats put refreshes between accesses
	localparam int CycleLimit = NumRows * Passes * 60 + 2000;

	logic Clock;
	logic Reset_L;
	cpuAddrT Address;
	dataWordT DataIn;
	logic UDS_L;
	logic LDS_L;
	logic DramSelect_L;
	logic WE_L;
	logic AS_L;
	dataWordT DataOut;
	logic Dtack_L;
	logic ResetOut_L;
	logic SDram_CKE_H;
	logic SDram_CS_L;
	logic SDram_RAS_L;
	logic SDram_CAS_L;
	logic SDram_WE_L;
	rowAddrT SDram_Addr;
	bankAddrT SDram_BA;
	wire dataWordT SDram_DQ;

	//////////////////////////////
	// stimulus table
	logic rowWrite [NumRows];
	cpuAddrT rowAddr [NumRows];
	dataWordT rowData [NumRows];	// refilled from $urandom each pass
	dataWordT shadow [cpuAddrT];	// last word written per address
	int cycles = 0;

	m68kDramController m68kDramController_inst (.*);

	sdramModel sdramModel_inst (
		.Clock(Clock),
		.CKE(SDram_CKE_H),
		.CS_L(SDram_CS_L),
		.RAS_L(SDram_RAS_L),
		.CAS_L(SDram_CAS_L),
		.WE_L(SDram_WE_L),
		.Addr(SDram_Addr),
		.BA(SDram_BA),
		.DQ(SDram_DQ)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("tests failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic cpuAddrT makeAddress(input bankAddrT bank, input rowAddrT row,
		input colAddrT col);
		cpuAddrT a;
		a = '0;
		a[BankHi:BankLo] = bank;
		a[RowHi:RowLo] = row;
		a[ColHi:ColLo] = col;
		return a;
	endfunction

	task automatic setRow(input int i, input logic write, input bankAddrT bank,
		input rowAddrT row, input colAddrT col);
		rowWrite[i] = write;
		rowAddr[i] = makeAddress(bank, row, col);
	endtask

	task automatic buildTable();
		setRow(0, 1'b1, 2'd0, 13'd0, 10'd0);
		setRow(1, 1'b0, 2'd0, 13'd0, 10'd0);
		setRow(2, 1'b1, 2'd1, 13'd5, 10'd17);
		setRow(3, 1'b1, 2'd2, 13'd8191, 10'd1023);	// top row and column
		setRow(4, 1'b1, 2'd3, 13'd4096, 10'd512);
		setRow(5, 1'b0, 2'd1, 13'd5, 10'd17);
		setRow(6, 1'b0, 2'd3, 13'd4096, 10'd512);
		setRow(7, 1'b0, 2'd2, 13'd8191, 10'd1023);
		setRow(8, 1'b1, 2'd0, 13'd0, 10'd0);	// overwrite
		setRow(9, 1'b0, 2'd0, 13'd0, 10'd0);
		setRow(10, 1'b1, 2'd0, 13'd1, 10'd0);	// same column, next row
		setRow(11, 1'b0, 2'd0, 13'd1, 10'd0);
		setRow(12, 1'b0, 2'd0, 13'd0, 10'd0);
		setRow(13, 1'b1, 2'd3, 13'd123, 10'd1);
		setRow(14, 1'b0, 2'd3, 13'd123, 10'd1);
		setRow(15, 1'b0, 2'd2, 13'd8191, 10'd1023);
		setRow(16, 1'b1, 2'd1, 13'd123, 10'd1);	// same row and column in other banks
		setRow(17, 1'b1, 2'd2, 13'd123, 10'd1);
		setRow(18, 1'b1, 2'd3, 13'd123, 10'd2);	// next column in bank 3
		setRow(19, 1'b0, 2'd3, 13'd123, 10'd1);
	endtask

	task automatic checkPowerUp();
		checkValue("Dtack_L after reset", 32'(Dtack_L), 32'd1);
		checkValue("memReqValid after reset", 32'(m68kDramController_inst.memReqValid), 32'd0);
		checkValue("memAck after reset", 32'(m68kDramController_inst.memAck), 32'd0);
		for (int i = 0; i < int'(PowerUpCycles); i++) begin
			@(negedge Clock);
			checkValue("CKE during power-up", 32'(SDram_CKE_H), 32'd0);
			checkValue("ResetOut_L during power-up", 32'(ResetOut_L), 32'd0);
		end
		while (!ResetOut_L)
			@(negedge Clock);
		checkValue("mode set before ResetOut_L", 32'(sdramModel_inst.modeSeen), 32'd1);
		checkValue("init command order", 32'(sdramModel_inst.orderGood), 32'd1);
		checkValue("mode register value", 32'(sdramModel_inst.modeReg), 32'(ModeRegisterValue));
	endtask

	//////////////////////////////
	// one full 68000 bus cycle
	task automatic applyRow(input int i);
		dataWordT expected;
		expected = '0;
		if (rowWrite[i])
			shadow[rowAddr[i]] = rowData[i];
		else
			expected = shadow[rowAddr[i]];
		@(negedge Clock);
		Address = rowAddr[i];
		DataIn = rowWrite[i] ? rowData[i] : 16'h0000;
		WE_L = !rowWrite[i];
		DramSelect_L = 1'b0;
		AS_L = 1'b0;
		if (rowWrite[i])
			@(negedge Clock);	// write strobes a clock after AS
		UDS_L = 1'b0;
		LDS_L = 1'b0;
		while (Dtack_L)
			@(negedge Clock);
		if (!rowWrite[i])
			checkValue($sformatf("row %0d read data", i), 32'(DataOut), 32'(expected));
		@(negedge Clock);
		checkValue("Dtack_L with both strobes low", 32'(Dtack_L), 32'd0);
		UDS_L = 1'b1;
		@(negedge Clock);
		checkValue("Dtack_L with LDS_L low", 32'(Dtack_L), 32'd0);
		LDS_L = 1'b1;
		AS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		@(negedge Clock);
		checkValue("Dtack_L after strobes high", 32'(Dtack_L), 32'd1);
	endtask

	initial begin
		void'($urandom(32'h8ff2_e9d3));
		Reset_L = 1'b0;
		Address = '0;
		DataIn = '0;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		AS_L = 1'b1;
		buildTable();
		repeat (8) @(negedge Clock);
		Reset_L = 1'b1;
		checkPowerUp();
		for (int p = 0; p < Passes; p++) begin
			for (int i = 0; i < NumRows; i++)
				rowData[i] = 16'($urandom);
			for (int i = 0; i < NumRows; i++)
				applyRow(i);
		end
		repeat (2 * int'(RefreshInterval)) @(negedge Clock);	// idle so only refreshes run
		checkValue("idle refreshes seen", 32'(sdramModel_inst.idleRefreshes >= 2), 32'd1);
		checkValue("refresh gap within limit",
			32'(sdramModel_inst.maxRefreshGap <= int'(RefreshInterval) + 40), 32'd1);
		checkValue("access to a closed bank", 32'(sdramModel_inst.accessError), 32'd0);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/sdramModel.sv */
`timescale 1ns/1ns
`default_nettype none

module sdramModel (
	input wire logic Clock,
	input wire logic CKE,
	input wire logic CS_L,
	input wire logic RAS_L,
	input wire logic CAS_L,
	input wire logic WE_L,
	input wire sdramPkg::rowAddrT Addr,
	input wire sdramPkg::bankAddrT BA,
	inout wire sdramPkg::dataWordT DQ
);
	import sdramPkg::*;

	dataWordT mem [int unsigned];	// sparse, key is bank, row, column
	rowAddrT openRow [4];
	logic [3:0] bankOpen = '0;
	sdramCmdT cmd;
	dataWordT readWord = '0;
	int readCount = 0;	// CAS latency countdown
	dataWordT dqOut = '0;
	logic dqOutEn = 1'b0;

	// init and refresh log, read by the testbench
	logic prechargeSeen = 1'b0;
	logic orderBroken = 1'b0;
	int initRefreshes = 0;
	logic modeSeen = 1'b0;
	logic orderGood = 1'b0;
	rowAddrT modeReg = '0;
	int idleRefreshes = 0;
	int sinceRefresh = 0;
	int maxRefreshGap = 0;
	logic accessError = 1'b0;	// read or write to a closed bank

	assign cmd = sdramCmdT'({CKE, CS_L, RAS_L, CAS_L, WE_L});
	assign DQ = dqOutEn ? dqOut : 'z;

	always @(posedge Clock) begin
		int unsigned key;
		key = {7'd0, BA, openRow[BA], Addr[9:0]};
		dqOutEn <= 1'b0;
		if (readCount != 0)
			readCount <= readCount - 1;
		if (readCount == int'(CasLatency)) begin
			dqOut <= readWord;	// out one clock after READ, still valid at the CL edge
			dqOutEn <= 1'b1;
		end
		if (modeSeen)
			sinceRefresh <= sinceRefresh + 1;
		case (cmd)
			PrechargeAll: begin
				bankOpen <= '0;
				if (!modeSeen && initRefreshes == 0)
					prechargeSeen <= 1'b1;
			end
			AutoRefresh: if (!modeSeen) begin
				if (prechargeSeen)
					initRefreshes <= initRefreshes + 1;
				else
					orderBroken <= 1'b1;	// refresh before the precharge
			end else begin
				if (idleRefreshes > 0 && sinceRefresh > maxRefreshGap)
					maxRefreshGap <= sinceRefresh;
				idleRefreshes <= idleRefreshes + 1;
				sinceRefresh <= 1;
			end
			ModeRegisterSet: begin
				modeSeen <= 1'b1;
				modeReg <= Addr;
				orderGood <= prechargeSeen && initRefreshes > 0 && !orderBroken;
			end
			BankActivate: begin
				openRow[BA] <= Addr;
				bankOpen[BA] <= 1'b1;
			end
			ReadCmd: begin
				if (!bankOpen[BA])
					accessError <= 1'b1;
				readWord <= mem.exists(key) ? mem[key] : 16'hdead;
				readCount <= int'(CasLatency);
				if (Addr[AutoPrechargeBit])
					bankOpen[BA] <= 1'b0;
			end
			WriteCmd: begin
				if (!bankOpen[BA])
					accessError <= 1'b1;
				mem[key] = DQ;
				if (Addr[AutoPrechargeBit])
					bankOpen[BA] <= 1'b0;
			end
			default: ;	// NOP and CKE low
		endcase
	end

endmodule

`default_nettype wire
